// ==== verilog/soc_pkg.sv ====
package soc_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int TIMER_WIDTH = 2 * DATA_WIDTH;

    // Index 0 core, 1 debug, 2 DMA
    localparam int NB_INIT = 3;
    localparam int NB_REGION = 3;
    localparam int NB_PRIV = 4;

    localparam int SRAM_WORDS = 256;
    localparam int ROM_WORDS = 16;
    localparam int SRAM_AW = $clog2(SRAM_WORDS);
    localparam int ROM_AW = $clog2(ROM_WORDS);
    // Wide enough for the largest region, the CLINT
    localparam int TGT_OFFS_WIDTH = 14;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam logic [ADDR_WIDTH-1:0] ROM_BASE = 32'h0000_1000;
    localparam logic [ADDR_WIDTH-1:0] ROM_LENGTH = 32'h0000_0040;
    localparam logic [ADDR_WIDTH-1:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [ADDR_WIDTH-1:0] CLINT_LENGTH = 32'h0000_C000;
    localparam logic [ADDR_WIDTH-1:0] SRAM_BASE = 32'h8000_0000;
    localparam logic [ADDR_WIDTH-1:0] SRAM_LENGTH = 32'h0000_0400;

    localparam logic [ADDR_WIDTH-1:0] MTIMECMP_OFFSET = 32'h0000_4000;
    localparam logic [ADDR_WIDTH-1:0] MTIME_OFFSET = 32'h0000_BFF8;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_t;

    // Encoding doubles as the access table region index
    typedef enum logic [1:0] {
        REG_ROM,
        REG_CLINT,
        REG_SRAM,
        REG_NONE
    } region_e;

    typedef logic [1:0] init_idx_t;

    // Indexed as [initiator][region][privilege], bit set means allowed
    typedef logic [NB_INIT-1:0][NB_REGION-1:0][NB_PRIV-1:0] access_ctrl_t;

    typedef struct packed {
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] be;
        priv_lvl_t             priv;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        logic                  err;
    } bus_rsp_t;

    typedef struct packed {
        logic                      we;
        logic [TGT_OFFS_WIDTH-1:0] offs;
        logic [DATA_WIDTH-1:0]     wdata;
        logic [STRB_WIDTH-1:0]     be;
    } tgt_req_t;

    localparam logic [DATA_WIDTH-1:0] BOOT_IMAGE [ROM_WORDS] = '{
        32'hf140_2573, 32'h0000_0597, 32'h0405_8593, 32'h8000_02b7,
        32'h0002_8067, 32'h1050_0073, 32'hffdf_f06f, 32'h0000_0013,
        32'h1357_9bdf, 32'h2468_ace0, 32'h0f1e_2d3c, 32'h4b5a_6978,
        32'h8796_a5b4, 32'hc3d2_e1f0, 32'h5a5a_a5a5, 32'h0000_0001
    };

    // Byte lane merge for partial writes
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] new_word,
        input logic [STRB_WIDTH-1:0] be
    );
        logic [DATA_WIDTH-1:0] word;
        word = old_word;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return word;
    endfunction

endpackage

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import soc_pkg::*; (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic [NB_INIT-1:0] req_valid_i,
    input  bus_req_t           req_i [NB_INIT],
    output logic [NB_INIT-1:0] gnt_o,
    output logic               bus_valid_o,
    output bus_req_t           bus_req_o,
    output init_idx_t          bus_init_o,
    input  logic               rsp_valid_i,
    input  bus_rsp_t           rsp_i,
    output logic [NB_INIT-1:0] rsp_valid_o,
    output bus_rsp_t           rsp_o [NB_INIT]
);

    init_idx_t rr_ptr_q;
    init_idx_t rsp_idx_q;
    init_idx_t gnt_idx;
    logic      gnt_valid;

    // Search starts at the pointer, nearest requester wins
    always_comb begin
        int cand;
        gnt_valid = 1'b0;
        gnt_idx = '0;
        for (int i = NB_INIT - 1; i >= 0; i--) begin
            cand = (int'(rr_ptr_q) + i) % NB_INIT;
            if (req_valid_i[cand]) begin
                gnt_valid = 1'b1;
                gnt_idx = init_idx_t'(cand);
            end
        end
    end

    assign bus_valid_o = gnt_valid;
    assign bus_req_o = req_i[gnt_idx];
    assign bus_init_o = gnt_idx;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_ptr_q <= '0;
            rsp_idx_q <= '0;
        end else if (gnt_valid) begin
            rr_ptr_q <= (gnt_idx == init_idx_t'(NB_INIT - 1)) ? '0 : gnt_idx + 2'd1;
            rsp_idx_q <= gnt_idx;
        end
    end

    // Grant and response steering
    always_comb begin
        for (int k = 0; k < NB_INIT; k++) begin
            gnt_o[k] = gnt_valid && (gnt_idx == init_idx_t'(k));
            rsp_valid_o[k] = rsp_valid_i && (rsp_idx_q == init_idx_t'(k));
            rsp_o[k] = rsp_i;
        end
    end

endmodule

// ==== verilog/access_filter.sv ====
`timescale 1ns/1ps

module access_filter import soc_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  logic         bus_valid_i,
    input  bus_req_t     bus_req_i,
    input  init_idx_t    bus_init_i,
    input  access_ctrl_t access_ctrl_i,
    output logic         rom_sel_o,
    output logic         clint_sel_o,
    output logic         sram_sel_o,
    output tgt_req_t     tgt_req_o,
    output region_e      rsp_region_o,
    output logic         rsp_err_o
);

    region_e               region;
    logic [ADDR_WIDTH-1:0] base;
    logic [ADDR_WIDTH-1:0] byte_offs;
    logic                  allowed;
    logic                  access_ok;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------
    always_comb begin
        region = REG_NONE;
        base = '0;
        if ((bus_req_i.addr - ROM_BASE) < ROM_LENGTH) begin
            region = REG_ROM;
            base = ROM_BASE;
        end else if ((bus_req_i.addr - CLINT_BASE) < CLINT_LENGTH) begin
            region = REG_CLINT;
            base = CLINT_BASE;
        end else if ((bus_req_i.addr - SRAM_BASE) < SRAM_LENGTH) begin
            region = REG_SRAM;
            base = SRAM_BASE;
        end
    end

    // Table lookup, ROM is never writable
    always_comb begin
        allowed = 1'b0;
        if (region != REG_NONE) begin
            allowed = access_ctrl_i[bus_init_i][region][bus_req_i.priv];
        end
        access_ok = allowed && !(bus_req_i.we && region == REG_ROM);
    end

    assign rom_sel_o = bus_valid_i && access_ok && (region == REG_ROM);
    assign clint_sel_o = bus_valid_i && access_ok && (region == REG_CLINT);
    assign sram_sel_o = bus_valid_i && access_ok && (region == REG_SRAM);

    assign byte_offs = bus_req_i.addr - base;
    assign tgt_req_o = '{
        we:    bus_req_i.we,
        offs:  byte_offs[TGT_OFFS_WIDTH+1:2],
        wdata: bus_req_i.wdata,
        be:    bus_req_i.be
    };

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_region_o <= REG_NONE;
            rsp_err_o <= 1'b0;
        end else begin
            rsp_region_o <= region;
            rsp_err_o <= bus_valid_i && !access_ok;
        end
    end

endmodule

// ==== verilog/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom import soc_pkg::*; (
    input  logic                  clk_i,
    input  logic                  sel_i,
    input  logic [ROM_AW-1:0]     word_i,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    // Registered read of the boot image
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_o <= BOOT_IMAGE[word_i];
        end
    end

endmodule

// ==== verilog/data_sram.sv ====
`timescale 1ns/1ps

module data_sram import soc_pkg::*; (
    input  logic                  clk_i,
    input  logic                  sel_i,
    input  tgt_req_t              tgt_req_i,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    logic [DATA_WIDTH-1:0] mem [SRAM_WORDS];
    logic [SRAM_AW-1:0]    idx;

    assign idx = tgt_req_i.offs[SRAM_AW-1:0];

    // Read-first, a write returns the old word
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_o <= mem[idx];
            if (tgt_req_i.we) begin
                mem[idx] <= merge_bytes(mem[idx], tgt_req_i.wdata, tgt_req_i.be);
            end
        end
    end

endmodule

// ==== verilog/timer_clint.sv ====
`timescale 1ns/1ps

module timer_clint import soc_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  rtc_i,
    input  logic                  sel_i,
    input  tgt_req_t              tgt_req_i,
    output logic [DATA_WIDTH-1:0] rdata_o,
    output logic                  timer_irq_o
);

    logic [2:0]                  rtc_sync_q;
    logic                        rtc_rise;
    logic [TIMER_WIDTH-1:0]      mtime_q;
    logic [TIMER_WIDTH-1:0]      mtimecmp_q;
    logic [TGT_OFFS_WIDTH-2:0]   dword;
    logic                        hi_word;
    logic                        hit_mtime;
    logic                        hit_cmp;
    logic [DATA_WIDTH-1:0]       rd_word;

    // Both registers are 64-bit aligned, bit 0 of the word offset picks the half
    assign dword = tgt_req_i.offs[TGT_OFFS_WIDTH-1:1];
    assign hi_word = tgt_req_i.offs[0];
    assign hit_mtime = dword == MTIME_OFFSET[TGT_OFFS_WIDTH+1:3];
    assign hit_cmp = dword == MTIMECMP_OFFSET[TGT_OFFS_WIDTH+1:3];

    assign rtc_rise = rtc_sync_q[1] & ~rtc_sync_q[2];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rtc_sync_q <= '0;
            mtime_q <= '0;
            mtimecmp_q <= '1;
            timer_irq_o <= 1'b0;
        end else begin
            rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
            // Software write wins over the tick
            if (sel_i && tgt_req_i.we && hit_mtime) begin
                if (hi_word) begin
                    mtime_q[TIMER_WIDTH-1:DATA_WIDTH] <= merge_bytes(
                        mtime_q[TIMER_WIDTH-1:DATA_WIDTH], tgt_req_i.wdata, tgt_req_i.be);
                end else begin
                    mtime_q[DATA_WIDTH-1:0] <= merge_bytes(
                        mtime_q[DATA_WIDTH-1:0], tgt_req_i.wdata, tgt_req_i.be);
                end
            end else if (rtc_rise) begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (sel_i && tgt_req_i.we && hit_cmp) begin
                if (hi_word) begin
                    mtimecmp_q[TIMER_WIDTH-1:DATA_WIDTH] <= merge_bytes(
                        mtimecmp_q[TIMER_WIDTH-1:DATA_WIDTH], tgt_req_i.wdata, tgt_req_i.be);
                end else begin
                    mtimecmp_q[DATA_WIDTH-1:0] <= merge_bytes(
                        mtimecmp_q[DATA_WIDTH-1:0], tgt_req_i.wdata, tgt_req_i.be);
                end
            end
            timer_irq_o <= mtime_q >= mtimecmp_q;
        end
    end

    always_comb begin
        rd_word = '0;
        if (hit_mtime) begin
            rd_word = hi_word ? mtime_q[TIMER_WIDTH-1:DATA_WIDTH] : mtime_q[DATA_WIDTH-1:0];
        end else if (hit_cmp) begin
            rd_word = hi_word ? mtimecmp_q[TIMER_WIDTH-1:DATA_WIDTH]
                              : mtimecmp_q[DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_o <= rd_word;
        end
    end

endmodule

// ==== verilog/soc_fabric_top.sv ====
`timescale 1ns/1ps

module soc_fabric_top import soc_pkg::*; (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               rtc_i,
    input  access_ctrl_t       access_ctrl_i,
    input  logic [NB_INIT-1:0] req_valid_i,
    input  bus_req_t           req_i [NB_INIT],
    output logic [NB_INIT-1:0] gnt_o,
    output logic [NB_INIT-1:0] rsp_valid_o,
    output bus_rsp_t           rsp_o [NB_INIT],
    output logic               timer_irq_o
);

    logic                  bus_valid;
    bus_req_t              bus_req;
    init_idx_t             bus_init;
    logic                  rom_sel;
    logic                  clint_sel;
    logic                  sram_sel;
    tgt_req_t              tgt_req;
    region_e               rsp_region;
    logic                  rsp_err;
    logic [DATA_WIDTH-1:0] rom_rdata;
    logic [DATA_WIDTH-1:0] sram_rdata;
    logic [DATA_WIDTH-1:0] clint_rdata;
    logic                  rsp_valid_q;
    logic                  rsp_we_q;
    bus_rsp_t              rsp;

    bus_arbiter i_bus_arbiter (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .req_valid_i ( req_valid_i ),
        .req_i       ( req_i       ),
        .gnt_o       ( gnt_o       ),
        .bus_valid_o ( bus_valid   ),
        .bus_req_o   ( bus_req     ),
        .bus_init_o  ( bus_init    ),
        .rsp_valid_i ( rsp_valid_q ),
        .rsp_i       ( rsp         ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_o       ( rsp_o       )
    );

    access_filter i_access_filter (
        .clk_i         ( clk_i         ),
        .arst_n_i      ( arst_n_i      ),
        .bus_valid_i   ( bus_valid     ),
        .bus_req_i     ( bus_req       ),
        .bus_init_i    ( bus_init      ),
        .access_ctrl_i ( access_ctrl_i ),
        .rom_sel_o     ( rom_sel       ),
        .clint_sel_o   ( clint_sel     ),
        .sram_sel_o    ( sram_sel      ),
        .tgt_req_o     ( tgt_req       ),
        .rsp_region_o  ( rsp_region    ),
        .rsp_err_o     ( rsp_err       )
    );

    // ------------------------------------------------------------------------
    // Targets
    // ------------------------------------------------------------------------
    boot_rom i_boot_rom (
        .clk_i   ( clk_i                    ),
        .sel_i   ( rom_sel                  ),
        .word_i  ( tgt_req.offs[ROM_AW-1:0] ),
        .rdata_o ( rom_rdata                )
    );

    data_sram i_data_sram (
        .clk_i     ( clk_i      ),
        .sel_i     ( sram_sel   ),
        .tgt_req_i ( tgt_req    ),
        .rdata_o   ( sram_rdata )
    );

    timer_clint i_timer_clint (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .rtc_i       ( rtc_i       ),
        .sel_i       ( clint_sel   ),
        .tgt_req_i   ( tgt_req     ),
        .rdata_o     ( clint_rdata ),
        .timer_irq_o ( timer_irq_o )
    );

    // ------------------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
            rsp_we_q <= 1'b0;
        end else begin
            rsp_valid_q <= bus_valid;
            rsp_we_q <= bus_req.we;
        end
    end

    // Errors and writes carry no data
    always_comb begin
        rsp.err = rsp_err;
        rsp.rdata = '0;
        if (!rsp_err && !rsp_we_q) begin
            case (rsp_region)
                REG_ROM:   rsp.rdata = rom_rdata;
                REG_CLINT: rsp.rdata = clint_rdata;
                REG_SRAM:  rsp.rdata = sram_rdata;
                default:   rsp.rdata = '0;
            endcase
        end
    end

endmodule

// ==== tests/soc_fabric_tb.sv ====
`timescale 1ns/1ps

module soc_fabric_tb import soc_pkg::*; ();

    localparam int N_RAND_WR = 48;
    localparam int N_ACL = 150;
    localparam int N_FAIR = 30;
    localparam int N_TXN = 2 * SRAM_WORDS + 2 * N_RAND_WR + ROM_WORDS + 4 + N_ACL + 16
                         + NB_INIT * N_FAIR + 6;
    localparam int TIMEOUT_CYCLES = 4 * N_TXN + 200;

    localparam logic [ADDR_WIDTH-1:0] UNMAPPED [8] = '{
        32'h0000_0ffc, 32'h0000_1040, 32'h01ff_fffc, 32'h0200_c000,
        32'h7fff_fffc, 32'h8000_0400, 32'hffff_fffc, 32'h0000_0000
    };

    logic               clk = 1'b0;
    logic               arst_n;
    logic               rtc;
    access_ctrl_t       access_ctrl;
    logic [NB_INIT-1:0] req_valid;
    bus_req_t           req [NB_INIT];
    logic [NB_INIT-1:0] gnt;
    logic [NB_INIT-1:0] rsp_valid;
    bus_rsp_t           rsp [NB_INIT];
    logic               timer_irq;

    // Reference model state
    logic [DATA_WIDTH-1:0]  sram_m [SRAM_WORDS];
    logic [2*DATA_WIDTH-1:0] mtime_m;
    logic [2*DATA_WIDTH-1:0] mtimecmp_m;

    logic               pend;
    int                 pend_init;
    bus_rsp_t           pend_rsp;
    logic [NB_INIT-1:0] exp_mask;
    int                 waited [NB_INIT];
    int                 check_cnt;
    int                 err_cnt;
    int                 gnt_cnt;
    int                 rsp_cnt;
    int                 cycle_cnt;

    soc_fabric_top UUT (
        .clk_i         ( clk         ),
        .arst_n_i      ( arst_n      ),
        .rtc_i         ( rtc         ),
        .access_ctrl_i ( access_ctrl ),
        .req_valid_i   ( req_valid   ),
        .req_i         ( req         ),
        .gnt_o         ( gnt         ),
        .rsp_valid_o   ( rsp_valid   ),
        .rsp_o         ( rsp         ),
        .timer_irq_o   ( timer_irq   )
    );

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] apply_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] be);
        logic [31:0] w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return w;
    endfunction

    // 0 ROM, 1 CLINT, 2 SRAM, 3 unmapped
    function automatic int region_of(input logic [31:0] addr);
        if (addr >= 32'h0000_1000 && addr < 32'h0000_1040) return 0;
        if (addr >= 32'h0200_0000 && addr < 32'h0200_c000) return 1;
        if (addr >= 32'h8000_0000 && addr < 32'h8000_0400) return 2;
        return 3;
    endfunction

    function automatic bus_rsp_t predict(input int k, input bus_req_t r);
        bus_rsp_t    res;
        int          rg;
        logic [31:0] offs;
        logic [31:0] half;
        rg = region_of(r.addr);
        res.err = 1'b1;
        res.rdata = '0;
        if (rg == 3 || !access_ctrl[k][rg][r.priv] || (r.we && rg == 0)) begin
            return res;
        end
        res.err = 1'b0;
        case (rg)
            0: offs = r.addr - 32'h0000_1000;
            1: offs = r.addr - 32'h0200_0000;
            default: offs = r.addr - 32'h8000_0000;
        endcase
        if (rg == 0) begin
            res.rdata = BOOT_IMAGE[offs[5:2]];
        end else if (rg == 2) begin
            if (r.we) begin
                sram_m[offs[9:2]] = apply_bytes(sram_m[offs[9:2]], r.wdata, r.be);
            end else begin
                res.rdata = sram_m[offs[9:2]];
            end
        end else if (offs[15:3] == 13'h0800) begin
            half = mtimecmp_m[32*offs[2] +: 32];
            if (r.we) begin
                mtimecmp_m[32*offs[2] +: 32] = apply_bytes(half, r.wdata, r.be);
            end else begin
                res.rdata = half;
            end
        end else if (offs[15:3] == 13'h17ff) begin
            half = mtime_m[32*offs[2] +: 32];
            if (r.we) begin
                mtime_m[32*offs[2] +: 32] = apply_bytes(half, r.wdata, r.be);
            end else begin
                res.rdata = half;
            end
        end
        return res;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    function automatic bus_req_t build_req(input logic we, input logic [31:0] addr,
                                           input logic [31:0] wdata, input logic [3:0] be,
                                           input priv_lvl_t priv);
        bus_req_t r;
        r.we = we;
        r.addr = addr;
        r.wdata = wdata;
        r.be = be;
        r.priv = priv;
        return r;
    endfunction

    function automatic priv_lvl_t pick_priv();
        int p;
        p = $urandom % 3;
        return (p == 2) ? PRIV_M : priv_lvl_t'(p);
    endfunction

    function automatic bus_req_t random_req(input int sel);
        logic [31:0] addr;
        case (sel)
            0: addr = 32'h0000_1000 + 4 * ($urandom % ROM_WORDS);
            1: addr = 32'h0200_4000 + 4 * ($urandom % 2);
            2: addr = 32'h8000_0000 + 4 * ($urandom % SRAM_WORDS);
            default: addr = $urandom & 32'hffff_fffc;
        endcase
        return build_req($urandom % 2, addr, $urandom, 4'($urandom), pick_priv());
    endfunction

    // Holds the request until granted and leaves valid high
    task automatic send(input int k, input bus_req_t r);
        @(posedge clk);
        req_valid[k] <= 1'b1;
        req[k] <= r;
        do begin
            @(negedge clk);
        end while (!gnt[k]);
    endtask

    task automatic go_idle(input int k);
        @(posedge clk);
        req_valid[k] <= 1'b0;
    endtask

    task automatic xfer(input int k, input bus_req_t r);
        send(k, r);
        go_idle(k);
    endtask

    // Back to back requests from one initiator, then idle
    task automatic request_stream(input int k);
        for (int i = 0; i < N_FAIR; i++) begin
            send(k, random_req($urandom % 4));
        end
        go_idle(k);
    endtask

    task automatic tick_rtc(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            rtc <= 1'b1;
            repeat (4) @(posedge clk);
            rtc <= 1'b0;
            repeat (4) @(posedge clk);
            mtime_m++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Response and fairness monitor
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (!arst_n) begin
            check(gnt, '0, "grant during reset");
            check(rsp_valid, '0, "response during reset");
            check(timer_irq, 1'b0, "timer interrupt during reset");
        end else begin
            exp_mask = pend ? (3'b001 << pend_init) : 3'b000;
            check(rsp_valid, exp_mask, "response valid pattern");
            if (pend) begin
                check(rsp[pend_init], pend_rsp, $sformatf("response to initiator %0d",
                                                          pend_init));
            end
            rsp_cnt += $countones(rsp_valid);
            pend = 1'b0;
            check(gnt & (gnt - 3'd1), '0, "more than one grant");
            for (int k = 0; k < NB_INIT; k++) begin
                if (gnt[k]) begin
                    check(waited[k] <= 2, 1'b1, $sformatf("wait of initiator %0d", k));
                    waited[k] = 0;
                    pend = 1'b1;
                    pend_init = k;
                    pend_rsp = predict(k, req[k]);
                    gnt_cnt++;
                end else if (req_valid[k]) begin
                    waited[k]++;
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] addr_q [$];
        logic [63:0] ac_bits;
        void'($urandom(67));
        arst_n = 1'b0;
        rtc = 1'b0;
        access_ctrl = '1;
        req_valid = '0;
        for (int k = 0; k < NB_INIT; k++) begin
            req[k] = '0;
            waited[k] = 0;
        end
        pend = 1'b0;
        pend_init = 0;
        pend_rsp = '0;
        check_cnt = 0;
        err_cnt = 0;
        gnt_cnt = 0;
        rsp_cnt = 0;
        mtime_m = '0;
        mtimecmp_m = '1;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        // Fill SRAM with a pattern of the whole word index
        for (int i = 0; i < SRAM_WORDS; i++) begin
            a = 32'h8000_0000 + 4 * i;
            xfer(i % NB_INIT, build_req(1'b1, a, {8'(i) ^ 8'h5a, ~8'(i), 8'(i), 8'hc3},
                                        4'hf, PRIV_M));
        end

        // Partial writes then readback
        for (int i = 0; i < N_RAND_WR; i++) begin
            a = 32'h8000_0000 + 4 * ($urandom % SRAM_WORDS);
            addr_q.push_back(a);
            xfer($urandom % NB_INIT, build_req(1'b1, a, $urandom, 4'($urandom), pick_priv()));
        end
        foreach (addr_q[i]) begin
            xfer($urandom % NB_INIT, build_req(1'b0, addr_q[i], '0, 4'hf, pick_priv()));
        end

        // Boot ROM
        for (int i = 0; i < ROM_WORDS; i++) begin
            xfer($urandom % NB_INIT, build_req(1'b0, 32'h0000_1000 + 4 * i, '0, 4'hf,
                                               pick_priv()));
        end
        for (int i = 0; i < 4; i++) begin
            xfer(i % NB_INIT, build_req(1'b1, 32'h0000_1000 + 4 * i, $urandom, 4'hf, PRIV_M));
        end

        // Random access table and privileges
        for (int i = 0; i < N_ACL; i++) begin
            if (i % 25 == 0) begin
                ac_bits = {$urandom, $urandom};
                @(posedge clk);
                access_ctrl <= ac_bits[$bits(access_ctrl_t)-1:0];
            end
            xfer($urandom % NB_INIT, random_req($urandom % 4));
        end
        @(posedge clk);
        access_ctrl <= '1;

        for (int i = 0; i < 8; i++) begin
            xfer(i % NB_INIT, build_req($urandom % 2, UNMAPPED[i], $urandom, 4'hf, PRIV_M));
            xfer(i % NB_INIT, random_req(3));
        end

        // All initiators requesting back to back
        fork
            request_stream(0);
            request_stream(1);
            request_stream(2);
        join

        for (int i = 0; i < SRAM_WORDS; i++) begin
            xfer(i % NB_INIT, build_req(1'b0, 32'h8000_0000 + 4 * i, '0, 4'hf, PRIV_U));
        end

        // ------------------------------------------------------------------------
        // Timer
        // ------------------------------------------------------------------------
        tick_rtc(10);
        xfer(0, build_req(1'b0, 32'h0200_bff8, '0, 4'hf, PRIV_M));
        xfer(1, build_req(1'b0, 32'h0200_bffc, '0, 4'hf, PRIV_M));
        xfer(0, build_req(1'b1, 32'h0200_4004, '0, 4'hf, PRIV_M));
        xfer(0, build_req(1'b1, 32'h0200_4000, mtime_m[31:0] + 32'd2, 4'hf, PRIV_M));
        repeat (3) @(negedge clk);
        check(timer_irq, mtime_m >= mtimecmp_m, "timer interrupt below compare");
        tick_rtc(3);
        @(negedge clk);
        check(timer_irq, mtime_m >= mtimecmp_m, "timer interrupt past compare");
        xfer(2, build_req(1'b1, 32'h0200_4000, mtime_m[31:0] + 32'd5, 4'hf, PRIV_M));
        repeat (3) @(negedge clk);
        check(timer_irq, mtime_m >= mtimecmp_m, "timer interrupt after compare raised");
        xfer(1, build_req(1'b0, 32'h0200_bff8, '0, 4'hf, PRIV_S));

        repeat (4) @(negedge clk);
        check(rsp_cnt, gnt_cnt, "responses against grants");
        $display("checks: %0d  errors: %0d  grants: %0d  responses: %0d",
                 check_cnt, err_cnt, gnt_cnt, rsp_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/soc_pkg.sv
verilog/bus_arbiter.sv
verilog/access_filter.sv
verilog/boot_rom.sv
verilog/data_sram.sv
verilog/timer_clint.sv
verilog/soc_fabric_top.sv
tests/soc_fabric_tb.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - files:
      - verilog/soc_pkg.sv
      - verilog/bus_arbiter.sv
      - verilog/access_filter.sv
      - verilog/boot_rom.sv
      - verilog/data_sram.sv
      - verilog/timer_clint.sv
      - verilog/soc_fabric_top.sv
  - target: test
    files:
      - tests/soc_fabric_tb.sv
